/* logic/seed_ext_macros.svh */
`ifndef SEED_EXT_MACROS_SVH
`define SEED_EXT_MACROS_SVH

// ----------------------------------------
// field widths
// ----------------------------------------
`define READ_NUM_W 9   // read number
`define POS_W      7   // base position in a read
`define IDX_W      64  // interval bound k / l
`define ADDR_W     32  // occurrence block address
`define CNT_W      64  // occurrence count

// ----------------------------------------
// occurrence table geometry
// ----------------------------------------
// one occurrence block covers 2^OCC_SHIFT bwt positions
`define OCC_SHIFT  7

// packed 2-bit bases per seed
`define MAX_BASES  64

`endif

/* logic/seed_ext_pkg.sv */
`include "seed_ext_macros.svh"

package seed_ext_pkg;

	// ----------------------------------------
	// enums
	// ----------------------------------------
	typedef enum logic [1:0] {
		A = 2'd0,
		C = 2'd1,
		G = 2'd2,
		T = 2'd3
	} base_e;

	typedef enum logic {
		SRC_FWD = 1'b0,
		SRC_BWD = 1'b1
	} src_e;

	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		REQ   = 2'd1,  // request on the occ port
		WAIT  = 2'd2,  // waiting for counts
		WRITE = 2'd3   // interval record out
	} ext_state_e;

	// ----------------------------------------
	// structs
	// ----------------------------------------
	typedef struct packed {
		logic [`READ_NUM_W-1:0]    read_num;
		logic [`IDX_W-1:0]         k;
		logic [`IDX_W-1:0]         l;
		logic [`POS_W-1:0]         start_pos;
		logic [`POS_W-1:0]         num_bases;
		logic [2*`MAX_BASES-1:0]   bases;  // step 0 in bits 1:0
	} seed_t;

	typedef struct packed {
		logic [`READ_NUM_W-1:0] read_num;
		logic [`ADDR_W-1:0]     addr_k;
		logic [`ADDR_W-1:0]     addr_l;
	} occ_req_t;

	typedef struct packed {
		logic [`READ_NUM_W-1:0] read_num;
		logic [`CNT_W-1:0]      occ_k;
		logic [`CNT_W-1:0]      occ_l;
	} occ_rsp_t;

	typedef struct packed {
		logic [`READ_NUM_W-1:0] read_num;
		logic [`POS_W-1:0]      pos;
		logic [`IDX_W-1:0]      k;
		logic [`IDX_W-1:0]      l;
		src_e                   src;
		logic                   last;  // final record of the seed
	} ivl_rec_t;

	// per-base offsets indexed by base code
	typedef logic [3:0][`IDX_W-1:0] base_off_t;

endpackage

/* logic/fwd_extend.sv */
`timescale 1ns/1ps
`include "seed_ext_macros.svh"

module fwd_extend (
	input  logic                    Clk_32UI,
	input  logic                    rst_n_i,
	input  logic                    start_i,
	input  seed_ext_pkg::seed_t     seed_i,
	input  seed_ext_pkg::base_off_t base_off_i,
	input  logic                    rsp_valid_i,
	input  seed_ext_pkg::occ_rsp_t  rsp_i,
	output logic                    req_valid_o,
	output seed_ext_pkg::occ_req_t  req_o,
	output logic                    rec_we_o,
	output seed_ext_pkg::ivl_rec_t  rec_o,
	output logic                    busy_o
);
	import seed_ext_pkg::*;

	localparam logic [`POS_W-1:0] POS_ONE = 1;

	ext_state_e              state_q;
	logic [`POS_W-1:0]       cnt_q;    // bases left to consume
	logic [2*`MAX_BASES-1:0] bases_q;  // current base in bits 1:0
	ivl_rec_t                rec_q;    // current interval and record

	base_e             cur_base;
	logic [`IDX_W-1:0] blk_k;
	logic [`IDX_W-1:0] blk_l;
	logic [`IDX_W-1:0] new_k;
	logic [`IDX_W-1:0] new_l;
	logic              start_empty;
	logic              step_last;

	// ----------------------------------------
	// next interval
	// ----------------------------------------
	assign cur_base    = base_e'(bases_q[1:0]);
	assign new_k       = base_off_i[cur_base] + rsp_i.occ_k;
	assign new_l       = base_off_i[cur_base] + rsp_i.occ_l;
	assign step_last   = (new_l <= new_k) || (cnt_q == POS_ONE);
	assign start_empty = (seed_i.l <= seed_i.k) || (seed_i.num_bases == '0);

	assign blk_k = rec_q.k >> `OCC_SHIFT;
	assign blk_l = rec_q.l >> `OCC_SHIFT;

	always_comb begin
		req_o.read_num = rec_q.read_num;
		req_o.addr_k   = blk_k[`ADDR_W-1:0];
		req_o.addr_l   = blk_l[`ADDR_W-1:0];
	end

	assign req_valid_o = (state_q == REQ);
	assign rec_we_o    = (state_q == WRITE);
	assign rec_o       = rec_q;
	assign busy_o      = (state_q != IDLE);

	// ----------------------------------------
	// FSM
	// ----------------------------------------
	always_ff @(posedge Clk_32UI or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= IDLE;
			cnt_q   <= '0;
		end else begin
			case (state_q)
				IDLE: begin
					if (start_i) begin
						cnt_q   <= seed_i.num_bases;
						state_q <= start_empty ? WRITE : REQ;  // empty seed gives one record
					end
				end
				REQ:  state_q <= WAIT;  // never held
				WAIT: begin
					if (rsp_valid_i) begin
						cnt_q   <= cnt_q - POS_ONE;
						state_q <= WRITE;
					end
				end
				WRITE: state_q <= rec_q.last ? IDLE : REQ;
				default: state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (state_q == IDLE && start_i) begin
			rec_q.read_num <= seed_i.read_num;
			rec_q.pos      <= seed_i.start_pos;
			rec_q.k        <= seed_i.k;
			rec_q.l        <= seed_i.l;
			rec_q.src      <= SRC_FWD;
			rec_q.last     <= 1'b1;
			bases_q        <= seed_i.bases;
		end
		if (state_q == WAIT && rsp_valid_i) begin
			rec_q.k    <= new_k;
			rec_q.l    <= new_l;
			rec_q.last <= step_last;
		end
		if (state_q == WRITE) begin
			rec_q.pos <= rec_q.pos + POS_ONE;  // walk upward
			bases_q   <= bases_q >> 2;
		end
	end

	// response must belong to this engine's outstanding request
	assert property (@(posedge Clk_32UI) disable iff (!rst_n_i)
		rsp_valid_i |-> (state_q == WAIT) && (rsp_i.read_num == rec_q.read_num))
		else $error("fwd_extend: response outside WAIT or for another read");

endmodule

/* logic/bwd_extend.sv */
`timescale 1ns/1ps
`include "seed_ext_macros.svh"

module bwd_extend (
	input  logic                    Clk_32UI,
	input  logic                    rst_n_i,
	input  logic                    start_i,
	input  seed_ext_pkg::seed_t     seed_i,
	input  seed_ext_pkg::base_off_t base_off_i,
	input  logic                    rsp_valid_i,
	input  seed_ext_pkg::occ_rsp_t  rsp_i,
	input  logic                    req_grant_i,
	input  logic                    rec_accept_i,
	output logic                    req_valid_o,
	output seed_ext_pkg::occ_req_t  req_o,
	output logic                    rec_we_o,
	output seed_ext_pkg::ivl_rec_t  rec_o,
	output logic                    busy_o
);
	import seed_ext_pkg::*;

	localparam logic [`POS_W-1:0] POS_ONE = 1;

	ext_state_e              state_q;
	logic [2*`MAX_BASES-1:0] bases_q;
	ivl_rec_t                rec_q;  // interval at rec_q.pos

	base_e             cur_base;
	logic [`IDX_W-1:0] blk_k;
	logic [`IDX_W-1:0] blk_l;
	logic [`IDX_W-1:0] new_k;
	logic [`IDX_W-1:0] new_l;
	logic              start_empty;
	logic              step_last;

	// ----------------------------------------
	// next interval
	// ----------------------------------------
	assign cur_base    = base_e'(bases_q[1:0]);
	assign new_k       = base_off_i[cur_base] + rsp_i.occ_k;
	assign new_l       = base_off_i[cur_base] + rsp_i.occ_l;
	assign step_last   = (new_l <= new_k) || (rec_q.pos == '0);  // position 0 ends the walk
	assign start_empty = (seed_i.l <= seed_i.k);

	assign blk_k = rec_q.k >> `OCC_SHIFT;
	assign blk_l = rec_q.l >> `OCC_SHIFT;

	always_comb begin
		req_o.read_num = rec_q.read_num;
		req_o.addr_k   = blk_k[`ADDR_W-1:0];
		req_o.addr_l   = blk_l[`ADDR_W-1:0];
	end

	assign req_valid_o = (state_q == REQ);
	assign rec_we_o    = (state_q == WRITE);
	assign rec_o       = rec_q;
	assign busy_o      = (state_q != IDLE);

	// ----------------------------------------
	// FSM held by the arbiter in REQ and WRITE
	// ----------------------------------------
	always_ff @(posedge Clk_32UI or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= IDLE;
		end else begin
			case (state_q)
				IDLE: begin
					if (start_i) begin
						state_q <= start_empty ? WRITE : REQ;
					end
				end
				REQ: begin
					if (req_grant_i) begin
						state_q <= WAIT;
					end
				end
				WAIT: begin
					if (rsp_valid_i) begin
						state_q <= WRITE;
					end
				end
				WRITE: begin
					if (rec_accept_i) begin
						state_q <= rec_q.last ? IDLE : REQ;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (state_q == IDLE && start_i) begin
			rec_q.read_num <= seed_i.read_num;
			rec_q.pos      <= seed_i.start_pos;
			rec_q.k        <= seed_i.k;
			rec_q.l        <= seed_i.l;
			rec_q.src      <= SRC_BWD;
			rec_q.last     <= 1'b1;
			bases_q        <= seed_i.bases;
		end
		if (state_q == WAIT && rsp_valid_i) begin
			rec_q.k    <= new_k;
			rec_q.l    <= new_l;
			rec_q.last <= step_last;
		end
		// step down only once the record has gone out
		if (state_q == WRITE && rec_accept_i && !rec_q.last) begin
			rec_q.pos <= rec_q.pos - POS_ONE;
			bases_q   <= bases_q >> 2;
		end
	end

	// a refused request stays up and unchanged
	assert property (@(posedge Clk_32UI) disable iff (!rst_n_i)
		req_valid_o && !req_grant_i |=> req_valid_o && $stable(req_o))
		else $error("bwd_extend: held request changed before grant");

	assert property (@(posedge Clk_32UI) disable iff (!rst_n_i)
		rsp_valid_i |-> (state_q == WAIT) && (rsp_i.read_num == rec_q.read_num))
		else $error("bwd_extend: response outside WAIT or for another read");

endmodule

/* logic/occ_arbiter.sv */
`timescale 1ns/1ps
`include "seed_ext_macros.svh"

module occ_arbiter (
	input  logic                   Clk_32UI,
	input  logic                   rst_n_i,
	input  logic                   fwd_req_valid_i,
	input  seed_ext_pkg::occ_req_t fwd_req_i,
	input  logic                   bwd_req_valid_i,
	input  seed_ext_pkg::occ_req_t bwd_req_i,
	input  logic                   fwd_rec_we_i,
	input  seed_ext_pkg::ivl_rec_t fwd_rec_i,
	input  logic                   bwd_rec_we_i,
	input  seed_ext_pkg::ivl_rec_t bwd_rec_i,
	input  logic                   occ_rsp_valid_i,
	input  seed_ext_pkg::occ_rsp_t occ_rsp_i,
	output logic                   bwd_req_grant_o,
	output logic                   bwd_rec_accept_o,
	output logic                   fwd_rsp_valid_o,
	output logic                   bwd_rsp_valid_o,
	output seed_ext_pkg::occ_rsp_t rsp_o,
	output logic                   occ_req_valid_o,
	output seed_ext_pkg::occ_req_t occ_req_o,
	output logic                   rec_we_o,
	output seed_ext_pkg::ivl_rec_t rec_o
);
	import seed_ext_pkg::*;

	logic [`READ_NUM_W-1:0] read_num_hold_q;  // last read number sent
	src_e [1:0]             src_fifo_q;       // who owns each outstanding request
	logic                   wr_ptr_q;
	logic                   rd_ptr_q;
	logic [1:0]             fifo_cnt_q;

	logic push;
	logic pop;
	src_e push_src;
	src_e head_src;

	// ----------------------------------------
	// request port, forward first
	// ----------------------------------------
	assign occ_req_valid_o = fwd_req_valid_i | bwd_req_valid_i;
	assign bwd_req_grant_o = ~fwd_req_valid_i;

	always_comb begin
		occ_req_o          = '0;
		occ_req_o.read_num = read_num_hold_q;  // idle port keeps the old read
		if (fwd_req_valid_i) begin
			occ_req_o = fwd_req_i;
		end else if (bwd_req_valid_i) begin
			occ_req_o = bwd_req_i;
		end
	end

	always_ff @(posedge Clk_32UI or negedge rst_n_i) begin
		if (!rst_n_i) begin
			read_num_hold_q <= '0;
		end else if (occ_req_valid_o) begin
			read_num_hold_q <= occ_req_o.read_num;
		end
	end

	// ----------------------------------------
	// source FIFO and response steering
	// ----------------------------------------
	assign push     = occ_req_valid_o;
	assign pop      = occ_rsp_valid_i;
	assign push_src = fwd_req_valid_i ? SRC_FWD : SRC_BWD;
	assign head_src = src_fifo_q[rd_ptr_q];

	always_ff @(posedge Clk_32UI) begin
		if (push) begin
			src_fifo_q[wr_ptr_q] <= push_src;
		end
	end

	always_ff @(posedge Clk_32UI or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr_q   <= 1'b0;
			rd_ptr_q   <= 1'b0;
			fifo_cnt_q <= 2'd0;
		end else begin
			if (push) begin
				wr_ptr_q <= ~wr_ptr_q;
			end
			if (pop) begin
				rd_ptr_q <= ~rd_ptr_q;
			end
			case ({push, pop})
				2'b10:   fifo_cnt_q <= fifo_cnt_q + 2'd1;
				2'b01:   fifo_cnt_q <= fifo_cnt_q - 2'd1;
				default: fifo_cnt_q <= fifo_cnt_q;
			endcase
		end
	end

	assign rsp_o           = occ_rsp_i;  // both engines see the payload and the strobes pick
	assign fwd_rsp_valid_o = occ_rsp_valid_i && (head_src == SRC_FWD);
	assign bwd_rsp_valid_o = occ_rsp_valid_i && (head_src == SRC_BWD);

	// ----------------------------------------
	// record write merge
	// ----------------------------------------
	assign rec_we_o         = fwd_rec_we_i | bwd_rec_we_i;
	assign bwd_rec_accept_o = ~fwd_rec_we_i;
	assign rec_o            = fwd_rec_we_i ? fwd_rec_i : (bwd_rec_we_i ? bwd_rec_i : '0);

	// at most one request per engine in flight
	assert property (@(posedge Clk_32UI) disable iff (!rst_n_i)
		push && (fifo_cnt_q == 2'd2) |-> pop)
		else $error("occ_arbiter: source FIFO overflow");

	assert property (@(posedge Clk_32UI) disable iff (!rst_n_i)
		pop |-> (fifo_cnt_q != 2'd0))
		else $error("occ_arbiter: response with no request outstanding");

endmodule

/* logic/seed_ext_top.sv */
`timescale 1ns/1ps

module seed_ext_top (
	input  logic                    Clk_32UI,
	input  logic                    rst_n_i,
	input  logic                    fwd_start_i,
	input  seed_ext_pkg::seed_t     fwd_seed_i,
	input  logic                    bwd_start_i,
	input  seed_ext_pkg::seed_t     bwd_seed_i,
	input  seed_ext_pkg::base_off_t base_off_i,
	input  logic                    occ_rsp_valid_i,
	input  seed_ext_pkg::occ_rsp_t  occ_rsp_i,
	output logic                    occ_req_valid_o,
	output seed_ext_pkg::occ_req_t  occ_req_o,
	output logic                    rec_we_o,
	output seed_ext_pkg::ivl_rec_t  rec_o,
	output logic                    fwd_busy_o,
	output logic                    bwd_busy_o
);
	import seed_ext_pkg::*;

	// engine side of the arbiter
	logic     fwd_req_valid;
	occ_req_t fwd_req;
	logic     fwd_rec_we;
	ivl_rec_t fwd_rec;
	logic     fwd_rsp_valid;
	logic     bwd_req_valid;
	occ_req_t bwd_req;
	logic     bwd_rec_we;
	ivl_rec_t bwd_rec;
	logic     bwd_rsp_valid;
	logic     bwd_req_grant;
	logic     bwd_rec_accept;
	occ_rsp_t rsp;

	fwd_extend fwd_extend_inst (
		.Clk_32UI    (Clk_32UI),
		.rst_n_i     (rst_n_i),
		.start_i     (fwd_start_i),
		.seed_i      (fwd_seed_i),
		.base_off_i  (base_off_i),
		.rsp_valid_i (fwd_rsp_valid),
		.rsp_i       (rsp),
		.req_valid_o (fwd_req_valid),
		.req_o       (fwd_req),
		.rec_we_o    (fwd_rec_we),
		.rec_o       (fwd_rec),
		.busy_o      (fwd_busy_o)
	);

	bwd_extend bwd_extend_inst (
		.Clk_32UI     (Clk_32UI),
		.rst_n_i      (rst_n_i),
		.start_i      (bwd_start_i),
		.seed_i       (bwd_seed_i),
		.base_off_i   (base_off_i),
		.rsp_valid_i  (bwd_rsp_valid),
		.rsp_i        (rsp),
		.req_grant_i  (bwd_req_grant),
		.rec_accept_i (bwd_rec_accept),
		.req_valid_o  (bwd_req_valid),
		.req_o        (bwd_req),
		.rec_we_o     (bwd_rec_we),
		.rec_o        (bwd_rec),
		.busy_o       (bwd_busy_o)
	);

	occ_arbiter occ_arbiter_inst (
		.Clk_32UI         (Clk_32UI),
		.rst_n_i          (rst_n_i),
		.fwd_req_valid_i  (fwd_req_valid),
		.fwd_req_i        (fwd_req),
		.bwd_req_valid_i  (bwd_req_valid),
		.bwd_req_i        (bwd_req),
		.fwd_rec_we_i     (fwd_rec_we),
		.fwd_rec_i        (fwd_rec),
		.bwd_rec_we_i     (bwd_rec_we),
		.bwd_rec_i        (bwd_rec),
		.occ_rsp_valid_i  (occ_rsp_valid_i),
		.occ_rsp_i        (occ_rsp_i),
		.bwd_req_grant_o  (bwd_req_grant),
		.bwd_rec_accept_o (bwd_rec_accept),
		.fwd_rsp_valid_o  (fwd_rsp_valid),
		.bwd_rsp_valid_o  (bwd_rsp_valid),
		.rsp_o            (rsp),
		.occ_req_valid_o  (occ_req_valid_o),
		.occ_req_o        (occ_req_o),
		.rec_we_o         (rec_we_o),
		.rec_o            (rec_o)
	);

endmodule

/* testbench/seed_ext_tb.sv */
`timescale 1ns/1ps
`include "seed_ext_macros.svh"

module seed_ext_tb;
	import seed_ext_pkg::*;

	localparam int NUM_ROWS    = 7;
	localparam int MEM_LAT     = 3;     // cycles from request to response
	localparam int ROW_TIMEOUT = 4000;  // cycles per row
	localparam int IDLE_WAIT   = 100;

	typedef struct packed {
		bit                fwd_en;
		bit                bwd_en;
		seed_t             fwd_seed;
		seed_t             bwd_seed;
		int                fwd_cnt;  // expected record count
		int                bwd_cnt;
		logic [`IDX_W-1:0] fwd_k;    // expected final interval
		logic [`IDX_W-1:0] fwd_l;
		logic [`IDX_W-1:0] bwd_k;
		logic [`IDX_W-1:0] bwd_l;
	} row_t;

	logic      Clk_32UI;
	logic      rst_n_i;
	logic      fwd_start_i;
	seed_t     fwd_seed_i;
	logic      bwd_start_i;
	seed_t     bwd_seed_i;
	base_off_t base_off_i;
	logic      occ_rsp_valid_i;
	occ_rsp_t  occ_rsp_i;
	logic      occ_req_valid_o;
	occ_req_t  occ_req_o;
	logic      rec_we_o;
	ivl_rec_t  rec_o;
	logic      fwd_busy_o;
	logic      bwd_busy_o;

	row_t rows [NUM_ROWS];

	// expectations per engine
	occ_req_t   fwd_req_exp[$];
	logic [1:0] fwd_base_exp[$];
	ivl_rec_t   fwd_rec_exp[$];
	occ_req_t   bwd_req_exp[$];
	logic [1:0] bwd_base_exp[$];
	ivl_rec_t   bwd_rec_exp[$];

	// memory model pipeline
	occ_rsp_t rsp_pend[$];
	int       rsp_due[$];

	int                     cyc;
	int                     errors;
	int                     checks;
	bit                     started;
	bit                     timed_out;
	logic [`READ_NUM_W-1:0] last_rn;
	logic [`READ_NUM_W-1:0] cur_fwd_rn;
	logic [`READ_NUM_W-1:0] cur_bwd_rn;
	int                     fwd_seen;
	int                     bwd_seen;
	ivl_rec_t               fwd_last;
	ivl_rec_t               bwd_last;

	seed_ext_top seed_ext_top_inst (
		.Clk_32UI        (Clk_32UI),
		.rst_n_i         (rst_n_i),
		.fwd_start_i     (fwd_start_i),
		.fwd_seed_i      (fwd_seed_i),
		.bwd_start_i     (bwd_start_i),
		.bwd_seed_i      (bwd_seed_i),
		.base_off_i      (base_off_i),
		.occ_rsp_valid_i (occ_rsp_valid_i),
		.occ_rsp_i       (occ_rsp_i),
		.occ_req_valid_o (occ_req_valid_o),
		.occ_req_o       (occ_req_o),
		.rec_we_o        (rec_we_o),
		.rec_o           (rec_o),
		.fwd_busy_o      (fwd_busy_o),
		.bwd_busy_o      (bwd_busy_o)
	);

	always #50 Clk_32UI = ~Clk_32UI;

	// ----------------------------------------
	// reference rules
	// ----------------------------------------
	// occurrence counts served by the memory model
	function automatic logic [`CNT_W-1:0] occ_count(input logic [`ADDR_W-1:0] addr,
			input logic [1:0] b, input bit is_l);
		occ_count = `CNT_W'(addr) * 3 + `CNT_W'(b) + (is_l ? 5 : 0);
	endfunction

	function automatic seed_t random_seed(input logic [`READ_NUM_W-1:0] rn,
			input int start_pos, input int nb);
		seed_t s;
		int    i;
		s.read_num  = rn;
		s.k         = {32'h0, $urandom};
		s.l         = s.k + ($urandom % 5000) + 1;
		s.start_pos = start_pos[`POS_W-1:0];
		s.num_bases = nb[`POS_W-1:0];
		for (i = 0; i < 4; i++) begin
			s.bases[32*i +: 32] = $urandom;
		end
		return s;
	endfunction

	// walk one seed and optionally queue the requests and records it must produce
	task automatic predict_seed(input seed_t s, input bit is_bwd, input bit push,
			output int cnt, output logic [`IDX_W-1:0] fin_k, output logic [`IDX_W-1:0] fin_l);
		logic [`IDX_W-1:0] k;
		logic [`IDX_W-1:0] l;
		logic [`POS_W-1:0] pos;
		logic [1:0]        b;
		occ_req_t          q;
		ivl_rec_t          r;
		int                steps;
		int                i;
		bit                done;
		k          = s.k;
		l          = s.l;
		pos        = s.start_pos;
		cnt        = 0;
		done       = 0;
		steps      = is_bwd ? int'(s.start_pos) + 1 : int'(s.num_bases);
		r.read_num = s.read_num;
		r.src      = is_bwd ? SRC_BWD : SRC_FWD;
		r.pos      = pos;
		r.k        = k;
		r.l        = l;
		r.last     = 1'b1;
		if (l <= k || steps == 0) begin  // empty seed, one record
			done = 1;
			cnt  = 1;
			if (push) begin
				if (is_bwd) bwd_rec_exp.push_back(r);
				else fwd_rec_exp.push_back(r);
			end
		end
		for (i = 0; i < steps && !done; i++) begin
			q.read_num = s.read_num;
			q.addr_k   = `ADDR_W'(k >> `OCC_SHIFT);
			q.addr_l   = `ADDR_W'(l >> `OCC_SHIFT);
			b          = s.bases[2*i +: 2];
			k          = base_off_i[b] + occ_count(q.addr_k, b, 1'b0);
			l          = base_off_i[b] + occ_count(q.addr_l, b, 1'b1);
			done       = (l <= k) || (i == steps - 1);
			r.pos      = pos;
			r.k        = k;
			r.l        = l;
			r.last     = done;
			cnt++;
			if (push && is_bwd) begin
				bwd_req_exp.push_back(q);
				bwd_base_exp.push_back(b);
				bwd_rec_exp.push_back(r);
			end else if (push) begin
				fwd_req_exp.push_back(q);
				fwd_base_exp.push_back(b);
				fwd_rec_exp.push_back(r);
			end
			pos = is_bwd ? pos - 1 : pos + 1;
		end
		fin_k = r.k;
		fin_l = r.l;
	endtask

	// ----------------------------------------
	// seed table
	// ----------------------------------------
	task automatic fill_table();
		int r;
		rows[0] = '{fwd_en: 1, bwd_en: 0, fwd_seed: random_seed(1, 3, 12),
			bwd_seed: random_seed(0, 0, 0), default: 0};
		rows[1] = '{fwd_en: 0, bwd_en: 1, fwd_seed: random_seed(0, 0, 0),
			bwd_seed: random_seed(2, 9, 0), default: 0};
		// same seeds together must match the solo runs
		rows[2] = '{fwd_en: 1, bwd_en: 1, fwd_seed: rows[0].fwd_seed,
			bwd_seed: rows[1].bwd_seed, default: 0};
		rows[3] = '{fwd_en: 1, bwd_en: 1, fwd_seed: random_seed(5, 10, 8),
			bwd_seed: random_seed(6, 20, 0), default: 0};
		rows[3].fwd_seed.l = rows[3].fwd_seed.k;  // l equal to k
		rows[3].bwd_seed.k = 64'h100;
		rows[3].bwd_seed.l = 64'h80_0000_0000;    // block address of l wraps to 0
		rows[4] = '{fwd_en: 1, bwd_en: 1, fwd_seed: random_seed(7, 2, 30),
			bwd_seed: random_seed(8, 30, 0), default: 0};
		rows[4].fwd_seed.k = 64'h100;
		rows[4].fwd_seed.l = 64'h80_0000_0000;
		rows[4].bwd_seed.l = rows[4].bwd_seed.k;
		rows[5] = '{fwd_en: 1, bwd_en: 1, fwd_seed: random_seed(9, 0, 64),
			bwd_seed: random_seed(10, 63, 0), default: 0};
		// both start empty so the two records collide and backward is held
		rows[6] = '{fwd_en: 1, bwd_en: 1, fwd_seed: random_seed(11, 5, 4),
			bwd_seed: random_seed(12, 7, 0), default: 0};
		rows[6].fwd_seed.l = rows[6].fwd_seed.k;
		rows[6].bwd_seed.l = rows[6].bwd_seed.k;
		for (r = 0; r < NUM_ROWS; r++) begin
			predict_seed(rows[r].fwd_seed, 1'b0, 1'b0, rows[r].fwd_cnt, rows[r].fwd_k,
				rows[r].fwd_l);
			predict_seed(rows[r].bwd_seed, 1'b1, 1'b0, rows[r].bwd_cnt, rows[r].bwd_k,
				rows[r].bwd_l);
		end
	endtask

	// ----------------------------------------
	// memory model and output monitor
	// ----------------------------------------
	always @(posedge Clk_32UI) begin
		cyc = cyc + 1;
		#2;
		if (rsp_due.size() > 0 && rsp_due[0] <= cyc) begin
			occ_rsp_valid_i = 1'b1;
			occ_rsp_i       = rsp_pend.pop_front();
			void'(rsp_due.pop_front());
		end else begin
			occ_rsp_valid_i = 1'b0;
		end
	end

	task automatic take_request();
		occ_req_t   want;
		occ_rsp_t   rsp;
		logic [1:0] b;
		bit         ok;
		ok = 1;
		if (occ_req_o.read_num == cur_fwd_rn && fwd_req_exp.size() > 0) begin
			want = fwd_req_exp.pop_front();
			b    = fwd_base_exp.pop_front();
		end else if (occ_req_o.read_num == cur_bwd_rn && bwd_req_exp.size() > 0) begin
			want = bwd_req_exp.pop_front();
			b    = bwd_base_exp.pop_front();
		end else begin
			ok = 0;
			errors++;
			$display("request for read %0d that no engine should issue", occ_req_o.read_num);
		end
		if (ok) begin
			checks++;
			if (occ_req_o !== want) begin
				errors++;
				$display("ERROR occ_req_o: got %h expected %h", occ_req_o, want);
			end
			rsp.read_num = occ_req_o.read_num;
			rsp.occ_k    = occ_count(occ_req_o.addr_k, b, 1'b0);
			rsp.occ_l    = occ_count(occ_req_o.addr_l, b, 1'b1);
			rsp_pend.push_back(rsp);
			rsp_due.push_back(cyc + MEM_LAT);
		end
		last_rn = occ_req_o.read_num;
	endtask

	task automatic take_record();
		ivl_rec_t want;
		bit       have;
		have = 0;
		if (rec_o.src == SRC_FWD && fwd_rec_exp.size() > 0) begin
			have = 1;
			want = fwd_rec_exp.pop_front();
			fwd_seen++;
			fwd_last = rec_o;
		end else if (rec_o.src == SRC_BWD && bwd_rec_exp.size() > 0) begin
			have = 1;
			want = bwd_rec_exp.pop_front();
			bwd_seen++;
			bwd_last = rec_o;
		end
		if (!have) begin
			errors++;
			$display("record written while none was expected from that engine");
		end else begin
			checks++;
			if (rec_o !== want) begin
				errors++;
				$display("ERROR rec_o: got %h expected %h", rec_o, want);
			end
		end
	endtask

	always @(negedge Clk_32UI) begin
		if (rst_n_i) begin
			if (!started && (occ_req_valid_o || rec_we_o || fwd_busy_o || bwd_busy_o)) begin
				errors++;
				$display("DUT outputs active before the first start");
			end
			if (occ_req_valid_o) begin
				take_request();
			end else begin
				checks++;
				if (occ_req_o.read_num !== last_rn) begin  // idle port holds the read number
					errors++;
					$display("ERROR occ_req_o.read_num: got %h expected %h",
						occ_req_o.read_num, last_rn);
				end
			end
			if (rec_we_o) begin
				take_record();
			end
		end
	end

	// ----------------------------------------
	// sequencing
	// ----------------------------------------
	task automatic end_run();
		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	endtask

	task automatic wait_engines_idle(input int limit, input string what);
		int n;
		n = 0;
		while ((fwd_busy_o || bwd_busy_o) && n < limit) begin
			@(posedge Clk_32UI);
			#2;
			n++;
		end
		if (fwd_busy_o || bwd_busy_o) begin
			errors++;
			timed_out = 1;
			$display("engines still busy after %0d cycles while waiting for %s", limit, what);
		end
	endtask

	task automatic check_value(input string name, input logic [`IDX_W-1:0] got,
			input logic [`IDX_W-1:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("ERROR %s: got %h expected %h", name, got, want);
		end
	endtask

	task automatic run_row(input int r);
		int                n;
		logic [`IDX_W-1:0] k;
		logic [`IDX_W-1:0] l;
		wait_engines_idle(IDLE_WAIT, "a free engine");
		if (!timed_out) begin
			fwd_seen   = 0;
			bwd_seen   = 0;
			cur_fwd_rn = rows[r].fwd_seed.read_num;
			cur_bwd_rn = rows[r].bwd_seed.read_num;
			if (rows[r].fwd_en) predict_seed(rows[r].fwd_seed, 1'b0, 1'b1, n, k, l);
			if (rows[r].bwd_en) predict_seed(rows[r].bwd_seed, 1'b1, 1'b1, n, k, l);
			@(posedge Clk_32UI);
			#2;
			fwd_seed_i  = rows[r].fwd_seed;
			bwd_seed_i  = rows[r].bwd_seed;
			fwd_start_i = rows[r].fwd_en;
			bwd_start_i = rows[r].bwd_en;
			started     = 1;
			@(posedge Clk_32UI);
			#2;
			fwd_start_i = 1'b0;
			bwd_start_i = 1'b0;
			wait_engines_idle(ROW_TIMEOUT, "the last record of a row");
		end
		if (!timed_out) begin
			check_value("fwd record count", fwd_seen, rows[r].fwd_en ? rows[r].fwd_cnt : 0);
			check_value("bwd record count", bwd_seen, rows[r].bwd_en ? rows[r].bwd_cnt : 0);
			if (rows[r].fwd_en) begin
				check_value("fwd final rec_o.k", fwd_last.k, rows[r].fwd_k);
				check_value("fwd final rec_o.l", fwd_last.l, rows[r].fwd_l);
			end
			if (rows[r].bwd_en) begin
				check_value("bwd final rec_o.k", bwd_last.k, rows[r].bwd_k);
				check_value("bwd final rec_o.l", bwd_last.l, rows[r].bwd_l);
			end
			if (fwd_rec_exp.size() + bwd_rec_exp.size() + fwd_req_exp.size() +
					bwd_req_exp.size() + rsp_pend.size() != 0) begin
				errors++;
				$display("row %0d ended with requests or records still missing", r);
			end
		end
	endtask

	initial begin
		int r;
		void'($urandom(32'hdda1_5d89));
		Clk_32UI        = 1'b0;
		rst_n_i         = 1'b0;
		fwd_start_i     = 1'b0;
		fwd_seed_i      = '0;
		bwd_start_i     = 1'b0;
		bwd_seed_i      = '0;
		occ_rsp_valid_i = 1'b0;
		occ_rsp_i       = '0;
		cyc             = 0;
		errors          = 0;
		checks          = 0;
		started         = 0;
		timed_out       = 0;
		last_rn         = '0;  // hold register clears on reset
		cur_fwd_rn      = '0;
		cur_bwd_rn      = '0;
		base_off_i[0]   = 64'd0;
		base_off_i[1]   = 64'd1000;
		base_off_i[2]   = 64'd2000;
		base_off_i[3]   = 64'd3000;
		fill_table();
		repeat (8) @(posedge Clk_32UI);
		#2;
		rst_n_i = 1'b1;
		repeat (4) @(posedge Clk_32UI);  // quiet cycles before any start
		#2;
		for (r = 0; r < NUM_ROWS && !timed_out; r++) begin
			run_row(r);
		end
		end_run();
	end

endmodule

/* sources.f */
+incdir+logic
logic/seed_ext_pkg.sv
logic/fwd_extend.sv
logic/bwd_extend.sv
logic/occ_arbiter.sv
logic/seed_ext_top.sv
testbench/seed_ext_tb.sv

/* Bender.yml */
package:
  name: seed_ext

sources:
  - include_dirs:
      - logic
    files:
      - logic/seed_ext_pkg.sv
      - logic/fwd_extend.sv
      - logic/bwd_extend.sv
      - logic/occ_arbiter.sv
      - logic/seed_ext_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/seed_ext_tb.sv
